// ==== Makefile ====
TOP := tb_vtp_translate

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+.
vtp_pkg.sv
vtp_page_table.sv
vtp_lookup_arbiter.sv
vtp_chan_translate.sv
vtp_translate_top.sv
vtp_translate_sva.sv
tb_vtp_translate.sv

// ==== tb_vtp_translate.sv ====
`timescale 1ns/1ps
`include "vtp_consts.svh"

module tb_vtp_translate;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int PT_ENTRIES = 1 << `VTP_PT_IDX_W;

    logic              clk;
    logic              rst;
    vtp_pkg::vtp_req_t c0_va;
    vtp_pkg::vtp_req_t c1_va;
    vtp_pkg::vtp_req_t c0_host;
    vtp_pkg::vtp_req_t c1_host;
    logic              va_almost_full_c0;
    logic              va_almost_full_c1;
    logic              host_almost_full_c0;
    logic              host_almost_full_c1;
    logic              error_c0;
    logic              error_c1;
    logic              pt_wr_valid;
    vtp_pkg::vtp_pte_t pt_wr_entry;

    // Reference copy of every page table entry written so far
    logic                  model_valid [PT_ENTRIES];
    logic [`VTP_VPN_W-1:0] model_vpn [PT_ENTRIES];
    logic [`VTP_VPN_W-1:0] model_ppn [PT_ENTRIES];

    int seed;
    int check_count;
    int mismatch_count;
    int timeout_count;

    vtp_translate_top i_vtp_translate_top
    (
        .clk                 (clk),
        .rst                 (rst),
        .c0_va               (c0_va),
        .c1_va               (c1_va),
        .va_almost_full_c0   (va_almost_full_c0),
        .va_almost_full_c1   (va_almost_full_c1),
        .c0_host             (c0_host),
        .c1_host             (c1_host),
        .host_almost_full_c0 (host_almost_full_c0),
        .host_almost_full_c1 (host_almost_full_c1),
        .error_c0            (error_c0),
        .error_c1            (error_c1),
        .pt_wr_valid         (pt_wr_valid),
        .pt_wr_entry         (pt_wr_entry)
    );

    always #2 clk = ~clk;

    // Direct-mapped lookup in the model, the full vpn must match
    function automatic logic model_hit(input logic [`VTP_ADDR_W-1:0] addr);
        logic [`VTP_PT_IDX_W-1:0] idx;
        idx = addr[`VTP_PAGE_BITS +: `VTP_PT_IDX_W];
        return model_valid[idx] && (model_vpn[idx] == addr[`VTP_ADDR_W-1:`VTP_PAGE_BITS]);
    endfunction

    // Physical address is the stored ppn followed by the untouched offset
    function automatic logic [`VTP_ADDR_W-1:0] model_translate(
        input logic [`VTP_ADDR_W-1:0] addr);
        logic [`VTP_PT_IDX_W-1:0] idx;
        idx = addr[`VTP_PAGE_BITS +: `VTP_PT_IDX_W];
        return {model_ppn[idx], addr[`VTP_PAGE_BITS-1:0]};
    endfunction

    function automatic vtp_pkg::vtp_req_t random_req(input vtp_pkg::vtp_op_t op,
                                                     input logic [`VTP_VPN_W-1:0] vpn);
        vtp_pkg::vtp_req_t req;
        logic [31:0] rnd;
        req.valid = 1'b1;
        req.op = op;
        rnd = $random(seed);
        req.addr = {vpn, rnd[`VTP_PAGE_BITS-1:0]};
        rnd = $random(seed);
        req.tag = rnd[`VTP_TAG_W-1:0];
        rnd = $random(seed);
        req.data = rnd[`VTP_DATA_W-1:0];
        return req;
    endfunction

    task automatic check_req(input vtp_pkg::vtp_req_t got, input vtp_pkg::vtp_req_t exp,
                             input string what);
        check_count++;
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s, got op %0d addr %h tag %h data %h", $time, what,
                     got.op, got.addr, got.tag, got.data);
            $display("    expected op %0d addr %h tag %h data %h",
                     exp.op, exp.addr, exp.tag, exp.data);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // Software fill through the write strobe, mirrored into the model
    task automatic write_entry(input logic [`VTP_VPN_W-1:0] vpn,
                               input logic [`VTP_VPN_W-1:0] ppn, input logic valid);
        @(posedge clk);
        #1;
        pt_wr_valid = 1'b1;
        pt_wr_entry.valid = valid;
        pt_wr_entry.vpn = vpn;
        pt_wr_entry.ppn = ppn;
        @(posedge clk);
        #1;
        pt_wr_valid = 1'b0;
        model_valid[vpn[`VTP_PT_IDX_W-1:0]] = valid;
        model_vpn[vpn[`VTP_PT_IDX_W-1:0]] = vpn;
        model_ppn[vpn[`VTP_PT_IDX_W-1:0]] = ppn;
    endtask

    // Present one request for one cycle once the channel is free
    task automatic send_req(input int ch, input vtp_pkg::vtp_req_t req);
        int cycles;
        logic busy;
        cycles = 0;
        busy = 1'b1;
        while (busy && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            busy = (ch == 0) ? va_almost_full_c0 : va_almost_full_c1;
            cycles++;
        end
        if (busy)
        begin
            $display("Timeout on channel %0d: the translator never became free", ch);
            timeout_count++;
        end
        else
        begin
            if (ch == 0) c0_va = req;
            else c1_va = req;
            @(posedge clk);
            #1;
            // The request was taken at the edge just passed
            if (ch == 0) c0_va.valid = 1'b0;
            else c1_va.valid = 1'b0;
        end
    endtask

    // Wait for either the host request or the error pulse of one channel
    task automatic await_result(input int ch, input vtp_pkg::vtp_req_t exp,
                                input logic want_error);
        int cycles;
        logic done;
        logic err;
        vtp_pkg::vtp_req_t got;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
            got = (ch == 0) ? c0_host : c1_host;
            err = (ch == 0) ? error_c0 : error_c1;
            if (got.valid || err)
            begin
                done = 1'b1;
                check_flag(err, want_error, $sformatf("c%0d error output", ch));
                if (want_error)
                    check_flag(got.valid, 1'b0, $sformatf("c%0d host valid with error", ch));
                else
                    check_req(got, exp, $sformatf("c%0d host request", ch));
            end
        end
        if (!done)
        begin
            $display("Timeout on channel %0d: the expected request or error never appeared",
                     ch);
            timeout_count++;
        end
        else
        begin
            // Nothing more may follow a single result
            @(negedge clk);
            got = (ch == 0) ? c0_host : c1_host;
            err = (ch == 0) ? error_c0 : error_c1;
            check_flag(err, 1'b0, $sformatf("c%0d error after result", ch));
            check_flag(got.valid, 1'b0, $sformatf("c%0d host valid after result", ch));
        end
    endtask

    // Expected result comes from the model, fences bypass the table
    task automatic translate_and_check(input int ch, input vtp_pkg::vtp_req_t req);
        vtp_pkg::vtp_req_t exp;
        logic miss;
        exp = req;
        miss = 1'b0;
        if (req.op != vtp_pkg::VTP_OP_FENCE)
        begin
            miss = !model_hit(req.addr);
            exp.addr = model_translate(req.addr);
        end
        send_req(ch, req);
        await_result(ch, exp, miss);
    endtask

    task automatic test_read_mapped();
        repeat (3) translate_and_check(0, random_req(vtp_pkg::VTP_OP_READ, 20'h00012));
    endtask

    task automatic test_write_mapped();
        repeat (3) translate_and_check(1, random_req(vtp_pkg::VTP_OP_WRITE, 20'h00025));
    endtask

    // Slot 0x12 holds vpn 0x00012, so 0x10012 aliases it and must miss
    task automatic test_miss();
        translate_and_check(0, random_req(vtp_pkg::VTP_OP_READ, 20'h00033));
        translate_and_check(1, random_req(vtp_pkg::VTP_OP_WRITE, 20'h10012));
        translate_and_check(0, random_req(vtp_pkg::VTP_OP_READ, 20'h10012));
    endtask

    task automatic test_fence();
        translate_and_check(1, random_req(vtp_pkg::VTP_OP_FENCE, 20'h00033));
    endtask

    // Both channels look up at once and contend for the arbiter
    task automatic test_parallel();
        vtp_pkg::vtp_req_t r0;
        vtp_pkg::vtp_req_t r1;
        for (int i = 0; i < 8; i++)
        begin
            r0 = random_req(vtp_pkg::VTP_OP_READ, 20'h00012);
            r1 = random_req(vtp_pkg::VTP_OP_WRITE, (i % 2 == 0) ? 20'h00025 : 20'h0003c);
            fork
                translate_and_check(0, r0);
                translate_and_check(1, r1);
            join
        end
    endtask

    task automatic test_remap_backpressure();
        vtp_pkg::vtp_req_t req;
        vtp_pkg::vtp_req_t exp;
        write_entry(20'h00012, 20'h0beef, 1'b1);
        translate_and_check(0, random_req(vtp_pkg::VTP_OP_READ, 20'h00012));
        req = random_req(vtp_pkg::VTP_OP_READ, 20'h00012);
        exp = req;
        exp.addr = model_translate(req.addr);
        send_req(0, req);
        // The host fills up while the lookup is in flight, the request still completes
        host_almost_full_c0 = 1'b1;
        await_result(0, exp, 1'b0);
        check_flag(va_almost_full_c0, 1'b1, "va_almost_full_c0 while host almost full");
        @(posedge clk);
        #1;
        host_almost_full_c0 = 1'b0;
        @(negedge clk);
        check_flag(va_almost_full_c0, 1'b0, "va_almost_full_c0 after host drains");
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        c0_va = '0;
        c1_va = '0;
        host_almost_full_c0 = 1'b0;
        host_almost_full_c1 = 1'b0;
        pt_wr_valid = 1'b0;
        pt_wr_entry = '0;
        seed = 32'hf0ef;
        check_count = 0;
        mismatch_count = 0;
        timeout_count = 0;
        for (int i = 0; i < PT_ENTRIES; i++)
        begin
            model_valid[i] = 1'b0;
            model_vpn[i] = '0;
            model_ppn[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag(c0_host.valid, 1'b0, "c0 host valid after reset");
        check_flag(c1_host.valid, 1'b0, "c1 host valid after reset");
        check_flag(error_c0 | error_c1, 1'b0, "error outputs after reset");
        check_flag(va_almost_full_c0 | va_almost_full_c1, 1'b0, "va_almost_full after reset");
        write_entry(20'h00012, 20'h0abcd, 1'b1);
        write_entry(20'h00025, 20'h03344, 1'b1);
        write_entry(20'h0003c, 20'h77001, 1'b1);
        test_read_mapped();
        test_write_mapped();
        test_miss();
        test_fence();
        test_parallel();
        test_remap_backpressure();
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== vtp_chan_translate.sv ====
`timescale 1ns/1ps
`include "vtp_consts.svh"

module vtp_chan_translate
(
    input  logic                     clk,
    input  logic                     rst,
    input  vtp_pkg::vtp_req_t        va_req,
    output vtp_pkg::vtp_req_t        host_req,
    input  logic                     host_almost_full,
    output logic                     va_almost_full,
    output vtp_pkg::vtp_lookup_req_t lookup_req,
    input  logic                     lookup_grant,
    input  vtp_pkg::vtp_lookup_rsp_t lookup_rsp,
    output logic                     error
);

    vtp_pkg::vtp_chan_state_t state;
    vtp_pkg::vtp_chan_state_t state_next;

    // The one request in flight, held while its page is looked up
    vtp_pkg::vtp_req_t req_q;

    // Outgoing request, payload and valid kept in separate registers
    vtp_pkg::vtp_req_t host_payload;
    logic              host_valid;
    logic              error_q;

    logic accept;
    logic is_fence;
    logic fence_pass;
    logic rsp_done;

    // Upstream keeps valid low while va_almost_full is high, so in idle
    // any valid request can be taken
    assign accept     = (state == vtp_pkg::CHAN_IDLE) && va_req.valid;
    assign is_fence   = (va_req.op == vtp_pkg::VTP_OP_FENCE);
    assign fence_pass = accept && is_fence;
    assign rsp_done   = (state == vtp_pkg::CHAN_WAIT) && lookup_rsp.valid;

    // Busy while a request is held, or while the host side is nearly full
    assign va_almost_full = (state != vtp_pkg::CHAN_IDLE) || host_almost_full;

    always_comb
    begin
        lookup_req.valid = (state == vtp_pkg::CHAN_LOOKUP);
        lookup_req.vpn   = req_q.addr[`VTP_ADDR_W-1:`VTP_PAGE_BITS];
    end

    always_comb
    begin
        state_next = state;
        case (state)
            vtp_pkg::CHAN_IDLE:
            begin
                // Fences go straight out and never leave idle
                if (accept && !is_fence)
                begin
                    state_next = vtp_pkg::CHAN_LOOKUP;
                end
            end
            vtp_pkg::CHAN_LOOKUP:
            begin
                // Stay here for every lost arbitration
                if (lookup_grant)
                begin
                    state_next = vtp_pkg::CHAN_WAIT;
                end
            end
            vtp_pkg::CHAN_WAIT:
            begin
                if (lookup_rsp.valid)
                begin
                    state_next = vtp_pkg::CHAN_IDLE;
                end
            end
            default:
            begin
                state_next = vtp_pkg::CHAN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= vtp_pkg::CHAN_IDLE;
            host_valid <= 1'b0;
            error_q    <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            host_valid <= fence_pass || (rsp_done && lookup_rsp.hit);
            // A miss drops the request, this pulse is all that remains of it
            error_q    <= rsp_done && !lookup_rsp.hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q <= va_req;
        end

        if (fence_pass)
        begin
            host_payload <= va_req;
        end
        else if (rsp_done)
        begin
            // Tag, data and op stay as issued, only the page number changes
            host_payload      <= req_q;
            host_payload.addr <= {lookup_rsp.ppn, req_q.addr[`VTP_PAGE_BITS-1:0]};
        end
    end

    always_comb
    begin
        host_req       = host_payload;
        host_req.valid = host_valid;
    end

    assign error = error_q;

endmodule

// ==== vtp_consts.svh ====
`ifndef VTP_CONSTS_SVH
`define VTP_CONSTS_SVH

// Width of both virtual and physical byte addresses
`define VTP_ADDR_W 32

// Page offset width, giving 4 KB pages
`define VTP_PAGE_BITS 12

// Page number width, shared by virtual and physical page numbers
`define VTP_VPN_W (`VTP_ADDR_W - `VTP_PAGE_BITS)

// Page table index width, giving 64 direct-mapped entries
`define VTP_PT_IDX_W 6

// Request tag width, carried through translation untouched
`define VTP_TAG_W 8

// Write data width, also carried through untouched
`define VTP_DATA_W 32

`endif

// ==== vtp_lookup_arbiter.sv ====
`timescale 1ns/1ps

module vtp_lookup_arbiter
(
    input  logic                     clk,
    input  logic                     rst,
    input  vtp_pkg::vtp_lookup_req_t req_c0,
    input  vtp_pkg::vtp_lookup_req_t req_c1,
    output vtp_pkg::vtp_lookup_rsp_t rsp_c0,
    output vtp_pkg::vtp_lookup_rsp_t rsp_c1,
    output vtp_pkg::vtp_lookup_req_t pt_req,
    input  vtp_pkg::vtp_lookup_rsp_t pt_rsp,
    output logic                     grant_c0,
    output logic                     grant_c1
);

    // Channel that won the most recent arbitration, 1 means c1
    logic last_grant;

    // Channel owning the lookup that the page table answers this cycle
    logic rsp_id;

    // On a tie, c0 wins only if c1 was the last one served
    assign grant_c0 = req_c0.valid && (!req_c1.valid || last_grant);
    assign grant_c1 = req_c1.valid && !grant_c0;

    // With no grant the c0 request is passed on, its valid is low anyway
    assign pt_req = grant_c1 ? req_c1 : req_c0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_grant <= 1'b1;
            rsp_id     <= 1'b0;
        end
        else if (grant_c0 || grant_c1)
        begin
            last_grant <= grant_c1;
            // The page table has a fixed one-cycle latency, so a single
            // register is enough to pair the answer with its requester
            rsp_id     <= grant_c1;
        end
    end

    // Both channels see the payload, only the owner sees valid
    always_comb
    begin
        rsp_c0       = pt_rsp;
        rsp_c0.valid = pt_rsp.valid && !rsp_id;
        rsp_c1       = pt_rsp;
        rsp_c1.valid = pt_rsp.valid && rsp_id;
    end

endmodule

// ==== vtp_page_table.sv ====
`timescale 1ns/1ps
`include "vtp_consts.svh"

module vtp_page_table
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_valid,
    input  vtp_pkg::vtp_pte_t        wr_entry,
    input  vtp_pkg::vtp_lookup_req_t lookup_req,
    output vtp_pkg::vtp_lookup_rsp_t lookup_rsp
);

    localparam int unsigned ENTRIES = 1 << `VTP_PT_IDX_W;

    // Valid bits live apart from the entry storage so reset can clear them
    logic [ENTRIES-1:0]    entry_valid;
    logic [`VTP_VPN_W-1:0] entry_vpn [ENTRIES];
    logic [`VTP_VPN_W-1:0] entry_ppn [ENTRIES];

    logic [`VTP_PT_IDX_W-1:0] wr_idx;
    logic [`VTP_PT_IDX_W-1:0] rd_idx;

    logic rsp_valid;
    logic rsp_hit;
    logic [`VTP_VPN_W-1:0] rsp_ppn;

    // Direct mapped, so the low vpn bits pick the slot
    assign wr_idx = wr_entry.vpn[`VTP_PT_IDX_W-1:0];
    assign rd_idx = lookup_req.vpn[`VTP_PT_IDX_W-1:0];

    // A write with valid clear invalidates the slot
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            entry_valid <= '0;
        end
        else if (wr_valid)
        begin
            entry_valid[wr_idx] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            entry_vpn[wr_idx] <= wr_entry.vpn;
            entry_ppn[wr_idx] <= wr_entry.ppn;
        end
    end

    // Response valid follows a lookup by exactly one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= lookup_req.valid;
        end
    end

    // Nonblocking reads see the table as it stood before a same-cycle write
    // A hit needs both the valid bit and a full vpn match
    always_ff @(posedge clk)
    begin
        rsp_hit <= entry_valid[rd_idx] && (entry_vpn[rd_idx] == lookup_req.vpn);
        rsp_ppn <= entry_ppn[rd_idx];
    end

    always_comb
    begin
        lookup_rsp.valid = rsp_valid;
        lookup_rsp.hit   = rsp_hit;
        lookup_rsp.ppn   = rsp_ppn;
    end

endmodule

// ==== vtp_pkg.sv ====
`include "vtp_consts.svh"

package vtp_pkg;

    // Request opcodes seen on both the virtual and the host side
    typedef enum logic [1:0]
    {
        VTP_OP_READ  = 2'd0,
        VTP_OP_WRITE = 2'd1,
        // A fence carries no address and skips the page table
        VTP_OP_FENCE = 2'd2
    } vtp_op_t;

    // Per-channel translator FSM states
    typedef enum logic [1:0]
    {
        CHAN_IDLE   = 2'd0,
        // Lookup is asserted toward the arbiter until it is granted
        CHAN_LOOKUP = 2'd1,
        // Lookup has left, the page table answers next cycle
        CHAN_WAIT   = 2'd2
    } vtp_chan_state_t;

    // Request as presented by the upstream side and reissued to the host
    // The same layout is used before and after translation
    typedef struct packed
    {
        logic                     valid;
        vtp_op_t                  op;
        logic [`VTP_ADDR_W-1:0]   addr;
        logic [`VTP_TAG_W-1:0]    tag;
        logic [`VTP_DATA_W-1:0]   data;
    } vtp_req_t;

    // Lookup request from a translator toward the page table
    typedef struct packed
    {
        logic                     valid;
        logic [`VTP_VPN_W-1:0]    vpn;
    } vtp_lookup_req_t;

    // Lookup response, ppn is only meaningful when hit is set
    typedef struct packed
    {
        logic                     valid;
        logic                     hit;
        logic [`VTP_VPN_W-1:0]    ppn;
    } vtp_lookup_rsp_t;

    // Page table entry as written by software
    // The full vpn is stored so aliases in the upper bits are detected
    typedef struct packed
    {
        logic                     valid;
        logic [`VTP_VPN_W-1:0]    vpn;
        logic [`VTP_VPN_W-1:0]    ppn;
    } vtp_pte_t;

endpackage

// ==== vtp_translate_sva.sv ====
`timescale 1ns/1ps

module vtp_translate_sva
(
    input logic              clk,
    input logic              rst,
    input vtp_pkg::vtp_req_t c0_host,
    input vtp_pkg::vtp_req_t c1_host,
    input logic              error_c0,
    input logic              error_c1
);

    // A dropped request never shows up on the host side in its error cycle
    err_host_excl_c0: assert property (@(posedge clk) disable iff (rst)
        !(error_c0 && c0_host.valid)) else $error("c0 error and host valid together");
    err_host_excl_c1: assert property (@(posedge clk) disable iff (rst)
        !(error_c1 && c1_host.valid)) else $error("c1 error and host valid together");

    // Each miss gives a single-cycle pulse
    err_pulse_c0: assert property (@(posedge clk) disable iff (rst)
        error_c0 |=> !error_c0) else $error("error_c0 longer than one cycle");
    err_pulse_c1: assert property (@(posedge clk) disable iff (rst)
        error_c1 |=> !error_c1) else $error("error_c1 longer than one cycle");

    // From the second reset cycle on the host side is quiet
    host_quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!c0_host.valid && !c1_host.valid))
        else $error("host valid high during reset");

endmodule

bind vtp_translate_top vtp_translate_sva u_sva
(
    .clk      (clk),
    .rst      (rst),
    .c0_host  (c0_host),
    .c1_host  (c1_host),
    .error_c0 (error_c0),
    .error_c1 (error_c1)
);

// ==== vtp_translate_top.sv ====
`timescale 1ns/1ps

module vtp_translate_top
(
    input  logic                 clk,
    input  logic                 rst,

    // Virtual side, c0 carries reads and c1 carries writes and fences
    input  vtp_pkg::vtp_req_t    c0_va,
    input  vtp_pkg::vtp_req_t    c1_va,
    output logic                 va_almost_full_c0,
    output logic                 va_almost_full_c1,

    // Host side, addresses already physical
    output vtp_pkg::vtp_req_t    c0_host,
    output vtp_pkg::vtp_req_t    c1_host,
    input  logic                 host_almost_full_c0,
    input  logic                 host_almost_full_c1,

    // One-cycle pulse per dropped request
    output logic                 error_c0,
    output logic                 error_c1,

    // Software fill port of the page table
    input  logic                 pt_wr_valid,
    input  vtp_pkg::vtp_pte_t    pt_wr_entry
);

    vtp_pkg::vtp_lookup_req_t lookup_req_c0;
    vtp_pkg::vtp_lookup_req_t lookup_req_c1;
    vtp_pkg::vtp_lookup_rsp_t lookup_rsp_c0;
    vtp_pkg::vtp_lookup_rsp_t lookup_rsp_c1;
    vtp_pkg::vtp_lookup_req_t pt_req;
    vtp_pkg::vtp_lookup_rsp_t pt_rsp;
    logic                     grant_c0;
    logic                     grant_c1;

    // Read channel translator
    vtp_chan_translate u_chan_c0
    (
        .clk              (clk),
        .rst              (rst),
        .va_req           (c0_va),
        .host_req         (c0_host),
        .host_almost_full (host_almost_full_c0),
        .va_almost_full   (va_almost_full_c0),
        .lookup_req       (lookup_req_c0),
        .lookup_grant     (grant_c0),
        .lookup_rsp       (lookup_rsp_c0),
        .error            (error_c0)
    );

    // Write and fence channel translator
    vtp_chan_translate u_chan_c1
    (
        .clk              (clk),
        .rst              (rst),
        .va_req           (c1_va),
        .host_req         (c1_host),
        .host_almost_full (host_almost_full_c1),
        .va_almost_full   (va_almost_full_c1),
        .lookup_req       (lookup_req_c1),
        .lookup_grant     (grant_c1),
        .lookup_rsp       (lookup_rsp_c1),
        .error            (error_c1)
    );

    // Both translators share the single lookup port through this arbiter
    vtp_lookup_arbiter u_arb
    (
        .clk      (clk),
        .rst      (rst),
        .req_c0   (lookup_req_c0),
        .req_c1   (lookup_req_c1),
        .rsp_c0   (lookup_rsp_c0),
        .rsp_c1   (lookup_rsp_c1),
        .pt_req   (pt_req),
        .pt_rsp   (pt_rsp),
        .grant_c0 (grant_c0),
        .grant_c1 (grant_c1)
    );

    vtp_page_table u_pt
    (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (pt_wr_valid),
        .wr_entry   (pt_wr_entry),
        .lookup_req (pt_req),
        .lookup_rsp (pt_rsp)
    );

endmodule
